//--- source/core_pkg.sv
// RV64I integer subset only (OP, OP-IMM, LUI); no loads, stores, branches or CSRs
package core_pkg;

	typedef logic [63:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [3:0] alu_op_t;

	localparam alu_op_t ALU_ADD    = 4'd0;
	localparam alu_op_t ALU_SUB    = 4'd1;
	localparam alu_op_t ALU_AND    = 4'd2;
	localparam alu_op_t ALU_OR     = 4'd3;
	localparam alu_op_t ALU_XOR    = 4'd4;
	localparam alu_op_t ALU_SLL    = 4'd5;
	localparam alu_op_t ALU_SRL    = 4'd6;
	localparam alu_op_t ALU_SRA    = 4'd7;
	localparam alu_op_t ALU_SLT    = 4'd8;
	localparam alu_op_t ALU_SLTU   = 4'd9;
	localparam alu_op_t ALU_PASS_B = 4'd10;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;

	// addi x0, x0, 0
	localparam inst_t NOP_INST = 32'h0000_0013;

	typedef enum logic {
		REQUESTING,
		RELEASING
	} fetch_state_e;

	typedef struct packed {
		logic valid;
		word_t pc;
		inst_t inst;
	} fetch_slot_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		inst_t inst;
		alu_op_t alu_op;
		reg_addr_t rs1_addr;
		reg_addr_t rs2_addr;
		word_t rs1_data;
		word_t rs2_data;
		word_t imm;
		logic use_imm;
		reg_addr_t rd_addr;
		logic rd_wena;
		logic illegal;
	} decoded_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		inst_t inst;
		reg_addr_t rd_addr;
		logic rd_wena;
		word_t rd_data;
		logic illegal;
	} commit_t;

endpackage

//--- source/fetch_unit.sv
// pc only steps by four; inst_addr may change only while inst_req is low, pc_start 4-aligned
`timescale 1ns/1ps

module fetch_unit #(
	parameter core_pkg::word_t pc_start = 64'h8000_0000
) (
	input logic clock,
	input logic reset,
	output logic inst_req,
	output core_pkg::word_t inst_addr,
	input logic inst_ack,
	input core_pkg::inst_t inst_data,
	output core_pkg::fetch_slot_t slot
);

	core_pkg::fetch_state_e state;
	core_pkg::word_t pc;
	logic capture;

	// ack seen while our request is up
	assign capture = (state == core_pkg::REQUESTING) && inst_req && inst_ack;
	assign inst_addr = pc;

	always_ff @(posedge clock) begin
		if (capture) begin
			slot.pc <= pc;
			slot.inst <= inst_data;
		end
		if (reset) begin
			state <= core_pkg::REQUESTING;
			inst_req <= 1'b0;
			pc <= pc_start;
			slot.valid <= 1'b0;
		end else begin
			slot.valid <= capture;
			case (state)
				core_pkg::REQUESTING: begin
					if (capture) begin
						inst_req <= 1'b0;
						pc <= pc + 64'd4;
						state <= core_pkg::RELEASING;
					end else begin
						inst_req <= 1'b1;
					end
				end
				core_pkg::RELEASING: begin
					// wait for the responder to drop ack
					if (!inst_ack) begin
						inst_req <= 1'b1;
						state <= core_pkg::REQUESTING;
					end
				end
				default: state <= core_pkg::REQUESTING;
			endcase
		end
	end

	addr_stable_during_req: assert property (
		@(posedge clock) disable iff (reset)
		inst_req |=> !inst_req || $stable(inst_addr)
	);

endmodule

//--- source/regfile.sv
// 32 x 64-bit, x0 reads zero, a same-cycle write is bypassed to both read ports
`timescale 1ns/1ps

module regfile (
	input logic clock,
	input logic reset,
	input core_pkg::reg_addr_t rs1_addr,
	input core_pkg::reg_addr_t rs2_addr,
	output core_pkg::word_t rs1_data,
	output core_pkg::word_t rs2_data,
	input core_pkg::commit_t write
);

	core_pkg::word_t regs [32];
	logic wena;

	assign wena = write.valid && write.rd_wena && (write.rd_addr != '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wena) begin
			regs[write.rd_addr] <= write.rd_data;
		end
	end

	function automatic core_pkg::word_t read_reg(input core_pkg::reg_addr_t addr);
		if (addr == '0)
			return '0;
		// writeback in flight wins
		if (wena && (write.rd_addr == addr))
			return write.rd_data;
		return regs[addr];
	endfunction

	always_comb begin
		rs1_data = read_reg(rs1_addr);
		rs2_data = read_reg(rs2_addr);
	end

	x0_stays_zero: assert property (
		@(posedge clock) disable iff (reset)
		write.valid && write.rd_wena && (write.rd_addr == '0) |=> regs[0] == '0
	);

endmodule

//--- source/decode_stage.sv
// decodes OP, OP-IMM and LUI only; every other opcode or funct7 is marked illegal
`timescale 1ns/1ps

module decode_stage (
	input logic clock,
	input logic reset,
	input core_pkg::fetch_slot_t slot,
	output core_pkg::reg_addr_t rs1_addr,
	output core_pkg::reg_addr_t rs2_addr,
	input core_pkg::word_t rs1_data,
	input core_pkg::word_t rs2_data,
	output core_pkg::decoded_t decoded
);

	core_pkg::inst_t inst;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	core_pkg::decoded_t dec_next;

	assign inst = slot.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];

	// alt selects sub or sra
	function automatic core_pkg::alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0: return alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
			3'd1: return core_pkg::ALU_SLL;
			3'd2: return core_pkg::ALU_SLT;
			3'd3: return core_pkg::ALU_SLTU;
			3'd4: return core_pkg::ALU_XOR;
			3'd5: return alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
			3'd6: return core_pkg::ALU_OR;
			default: return core_pkg::ALU_AND;
		endcase
	endfunction

	always_comb begin
		dec_next.valid = slot.valid;
		dec_next.pc = slot.pc;
		dec_next.inst = inst;
		dec_next.rs1_addr = rs1_addr;
		dec_next.rs2_addr = rs2_addr;
		dec_next.rs1_data = rs1_data;
		dec_next.rs2_data = rs2_data;
		dec_next.rd_addr = inst[11:7];
		dec_next.alu_op = core_pkg::ALU_ADD;
		dec_next.imm = {{52{inst[31]}}, inst[31:20]};
		dec_next.use_imm = 1'b0;
		dec_next.illegal = 1'b0;
		case (opcode)
			core_pkg::OPC_OP: begin
				dec_next.alu_op = alu_from_funct3(funct3, inst[30]);
				dec_next.illegal = !((funct7 == 7'b0000000) ||
					((funct7 == 7'b0100000) && ((funct3 == 3'd0) || (funct3 == 3'd5))));
			end
			core_pkg::OPC_OP_IMM: begin
				dec_next.use_imm = 1'b1;
				dec_next.alu_op = alu_from_funct3(funct3, inst[30] && (funct3 == 3'd5));
				// rv64 shifts keep a 6-bit shamt
				if (funct3 == 3'd1)
					dec_next.illegal = (inst[31:26] != 6'b000000);
				else if (funct3 == 3'd5)
					dec_next.illegal = (inst[31:26] != 6'b000000) && (inst[31:26] != 6'b010000);
			end
			core_pkg::OPC_LUI: begin
				dec_next.use_imm = 1'b1;
				dec_next.alu_op = core_pkg::ALU_PASS_B;
				dec_next.imm = {{32{inst[31]}}, inst[31:12], 12'b0};
			end
			default: dec_next.illegal = 1'b1;
		endcase
		dec_next.rd_wena = !dec_next.illegal;
	end

	always_ff @(posedge clock) begin
		decoded <= dec_next;
		if (reset)
			decoded.valid <= 1'b0;
	end

endmodule

//--- source/execute_stage.sv
// forwards only from its own commit register; older results must come through the regfile
`timescale 1ns/1ps

module execute_stage (
	input logic clock,
	input logic reset,
	input core_pkg::decoded_t decoded,
	output core_pkg::commit_t commit
);

	logic fwd_ok;
	logic fwd_rs1;
	logic fwd_rs2;
	core_pkg::word_t op_a;
	core_pkg::word_t rs2_val;
	core_pkg::word_t op_b;
	logic [5:0] shamt;
	core_pkg::word_t result;
	core_pkg::commit_t cmt_next;

	// previous instruction still sits in the commit register
	assign fwd_ok = commit.valid && commit.rd_wena && (commit.rd_addr != '0);
	assign fwd_rs1 = fwd_ok && (commit.rd_addr == decoded.rs1_addr);
	assign fwd_rs2 = fwd_ok && (commit.rd_addr == decoded.rs2_addr);

	assign op_a = fwd_rs1 ? commit.rd_data : decoded.rs1_data;
	assign rs2_val = fwd_rs2 ? commit.rd_data : decoded.rs2_data;
	assign op_b = decoded.use_imm ? decoded.imm : rs2_val;
	assign shamt = op_b[5:0];

	always_comb begin
		case (decoded.alu_op)
			core_pkg::ALU_ADD: result = op_a + op_b;
			core_pkg::ALU_SUB: result = op_a - op_b;
			core_pkg::ALU_AND: result = op_a & op_b;
			core_pkg::ALU_OR: result = op_a | op_b;
			core_pkg::ALU_XOR: result = op_a ^ op_b;
			core_pkg::ALU_SLL: result = op_a << shamt;
			core_pkg::ALU_SRL: result = op_a >> shamt;
			core_pkg::ALU_SRA: result = $signed(op_a) >>> shamt;
			core_pkg::ALU_SLT: result = {63'b0, $signed(op_a) < $signed(op_b)};
			core_pkg::ALU_SLTU: result = {63'b0, op_a < op_b};
			// lui
			core_pkg::ALU_PASS_B: result = op_b;
			default: result = '0;
		endcase
	end

	always_comb begin
		cmt_next.valid = decoded.valid;
		cmt_next.pc = decoded.pc;
		cmt_next.inst = decoded.inst;
		cmt_next.rd_addr = decoded.rd_addr;
		cmt_next.rd_wena = decoded.rd_wena;
		cmt_next.rd_data = result;
		cmt_next.illegal = decoded.illegal;
	end

	always_ff @(posedge clock) begin
		commit <= cmt_next;
		if (reset)
			commit.valid <= 1'b0;
	end

	illegal_never_writes: assert property (
		@(posedge clock) disable iff (reset)
		commit.valid |-> !(commit.illegal && commit.rd_wena)
	);

endmodule

//--- source/core_top.sv
// four-stage RV64I subset; no stalls, commit is a one-cycle pulse with no back-pressure
`timescale 1ns/1ps

module core_top #(
	parameter core_pkg::word_t pc_start = 64'h8000_0000
) (
	input logic clock,
	input logic reset,
	output logic inst_req,
	output core_pkg::word_t inst_addr,
	input logic inst_ack,
	input core_pkg::inst_t inst_data,
	output core_pkg::commit_t commit
);

	core_pkg::fetch_slot_t slot;
	core_pkg::reg_addr_t rs1_addr;
	core_pkg::reg_addr_t rs2_addr;
	core_pkg::word_t rs1_data;
	core_pkg::word_t rs2_data;
	core_pkg::decoded_t decoded;

	fetch_unit #(
		.pc_start(pc_start)
	) i_fetch (
		.clock(clock),
		.reset(reset),
		.inst_req(inst_req),
		.inst_addr(inst_addr),
		.inst_ack(inst_ack),
		.inst_data(inst_data),
		.slot(slot)
	);

	// commit record doubles as the write port
	regfile i_regfile (
		.clock(clock),
		.reset(reset),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.write(commit)
	);

	decode_stage i_decode (
		.clock(clock),
		.reset(reset),
		.slot(slot),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.decoded(decoded)
	);

	execute_stage i_execute (
		.clock(clock),
		.reset(reset),
		.decoded(decoded),
		.commit(commit)
	);

endmodule

//--- tests/tb_cases.svh
// row i is fetched from pc_start + 4*i; rd is the instruction's rd field; filled at time zero
localparam int NUM_CASES = 36;

typedef struct packed {
	core_pkg::inst_t inst;
	core_pkg::word_t value;
	logic illegal;
	logic no_delay;
} case_t;

case_t cases [NUM_CASES];
string case_names [NUM_CASES];
int cases_filled = 0;

function automatic core_pkg::inst_t r_type(input logic [6:0] f7, input core_pkg::reg_addr_t rs2,
		input core_pkg::reg_addr_t rs1, input logic [2:0] f3, input core_pkg::reg_addr_t rd);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic core_pkg::inst_t i_type(input logic [11:0] imm, input core_pkg::reg_addr_t rs1,
		input logic [2:0] f3, input core_pkg::reg_addr_t rd);
	return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic core_pkg::inst_t u_type(input logic [19:0] imm, input core_pkg::reg_addr_t rd);
	return {imm, rd, 7'b0110111};
endfunction

task automatic add_case(input string name, input core_pkg::inst_t inst,
		input core_pkg::word_t value, input int illegal, input int no_delay);
	case_names[cases_filled] = name;
	cases[cases_filled].inst = inst;
	cases[cases_filled].value = value;
	cases[cases_filled].illegal = (illegal != 0);
	cases[cases_filled].no_delay = (no_delay != 0);
	cases_filled++;
endtask

initial begin
	// x1 = 0x12345678 from lui then addi at distance one
	add_case("lui", u_type(20'h12345, 5'd1), 64'h0000_0000_1234_5000, 0, 0);
	add_case("addi_fwd", i_type(12'h678, 5'd1, 3'd0, 5'd1), 64'h0000_0000_1234_5678, 0, 0);
	// lui sign-extends bit 31
	add_case("lui_neg", u_type(20'h80000, 5'd2), 64'hffff_ffff_8000_0000, 0, 0);
	add_case("addi_m1", i_type(12'hfff, 5'd0, 3'd0, 5'd3), 64'hffff_ffff_ffff_ffff, 0, 0);
	add_case("addi_max", i_type(12'h7ff, 5'd0, 3'd0, 5'd4), 64'h0000_0000_0000_07ff, 0, 0);
	add_case("addi_min", i_type(12'h800, 5'd0, 3'd0, 5'd5), 64'hffff_ffff_ffff_f800, 0, 0);
	add_case("addi_36", i_type(12'd36, 5'd0, 3'd0, 5'd11), 64'd36, 0, 0);
	add_case("add", r_type(7'h00, 5'd4, 5'd1, 3'd0, 5'd6), 64'h0000_0000_1234_5e77, 0, 0);
	// x1 - x2 = x1 + 0x80000000
	add_case("sub", r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd7), 64'h0000_0000_9234_5678, 0, 0);
	add_case("and", r_type(7'h00, 5'd3, 5'd1, 3'd7, 5'd8), 64'h0000_0000_1234_5678, 0, 0);
	add_case("or", r_type(7'h00, 5'd4, 5'd2, 3'd6, 5'd9), 64'hffff_ffff_8000_07ff, 0, 0);
	add_case("xor", r_type(7'h00, 5'd3, 5'd1, 3'd4, 5'd10), 64'hffff_ffff_edcb_a987, 0, 0);
	add_case("sll", r_type(7'h00, 5'd11, 5'd1, 3'd1, 5'd12), 64'h2345_6780_0000_0000, 0, 0);
	// rs2 = 0x7ff, only the low six bits (63) count
	add_case("sll_mask", r_type(7'h00, 5'd4, 5'd3, 3'd1, 5'd13), 64'h8000_0000_0000_0000, 0, 0);
	add_case("srl", r_type(7'h00, 5'd11, 5'd2, 3'd5, 5'd14), 64'h0000_0000_0fff_ffff, 0, 0);
	add_case("sra", r_type(7'h20, 5'd11, 5'd2, 3'd5, 5'd15), 64'hffff_ffff_ffff_ffff, 0, 0);
	add_case("slt", r_type(7'h00, 5'd1, 5'd2, 3'd2, 5'd16), 64'd1, 0, 0);
	add_case("sltu", r_type(7'h00, 5'd1, 5'd2, 3'd3, 5'd17), 64'd0, 0, 0);
	add_case("slti", i_type(12'hfff, 5'd5, 3'd2, 5'd18), 64'd1, 0, 0);
	add_case("sltiu", i_type(12'hfff, 5'd4, 3'd3, 5'd19), 64'd1, 0, 0);
	add_case("andi", i_type(12'h800, 5'd10, 3'd7, 5'd20), 64'hffff_ffff_edcb_a800, 0, 0);
	add_case("ori", i_type(12'h0ff, 5'd1, 3'd6, 5'd21), 64'h0000_0000_1234_56ff, 0, 0);
	add_case("xori", i_type(12'hfff, 5'd1, 3'd4, 5'd22), 64'hffff_ffff_edcb_a987, 0, 0);
	add_case("slli", i_type(12'd40, 5'd1, 3'd1, 5'd23), 64'h3456_7800_0000_0000, 0, 0);
	add_case("srli", i_type(12'd60, 5'd3, 3'd5, 5'd24), 64'd15, 0, 0);
	// srai x25, x9, 4
	add_case("srai", i_type(12'h404, 5'd9, 3'd5, 5'd25), 64'hffff_ffff_f800_007f, 0, 0);
	// chain fetched back to back: distances one, two and three
	add_case("dep_base", i_type(12'd5, 5'd0, 3'd0, 5'd26), 64'd5, 0, 1);
	add_case("dep_d1", i_type(12'd7, 5'd26, 3'd0, 5'd26), 64'd12, 0, 1);
	add_case("dep_d1b", i_type(12'd1, 5'd26, 3'd0, 5'd27), 64'd13, 0, 1);
	add_case("dep_d2", r_type(7'h00, 5'd27, 5'd26, 3'd0, 5'd28), 64'd25, 0, 1);
	add_case("dep_d3", r_type(7'h00, 5'd28, 5'd26, 3'd0, 5'd29), 64'd37, 0, 1);
	// result shows on the commit but x0 stays zero
	add_case("x0_write", i_type(12'd99, 5'd0, 3'd0, 5'd0), 64'd99, 0, 1);
	add_case("x0_read", i_type(12'd1, 5'd0, 3'd0, 5'd30), 64'd1, 0, 0);
	add_case("x31_set", i_type(12'd55, 5'd0, 3'd0, 5'd31), 64'd55, 0, 0);
	// sd x3, 31(x1); its rd field points at x31
	add_case("store", 32'h0030_bfa3, 64'd0, 1, 0);
	add_case("x31_kept", i_type(12'd1, 5'd31, 3'd0, 5'd30), 64'd56, 0, 0);
end

//--- tests/commit_checker.sv
// expects commits in table order starting at pc_start; commits past the last row are ignored
`timescale 1ns/1ps

module commit_checker #(
	parameter core_pkg::word_t pc_start = 64'h8000_0000
) (
	input logic clock,
	input logic reset,
	input logic inst_req,
	input core_pkg::word_t inst_addr,
	input core_pkg::commit_t commit,
	output logic done,
	output int error_count
);

	`include "tb_cases.svh"

	int row = 0;
	int passed = 0;
	int failed = 0;
	int errors = 0;
	logic finished = 1'b0;
	logic was_reset = 1'b1;
	logic addr_checked = 1'b0;
	core_pkg::word_t next_pc = pc_start;

	assign done = finished;
	assign error_count = errors;

	function automatic int field_differs(input string name, input string field,
			input core_pkg::word_t expected, input core_pkg::word_t actual);
		if (expected === actual)
			return 0;
		$display("[ERROR] %s %s: expected %h, actual %h", name, field, expected, actual);
		return 1;
	endfunction

	task automatic check_commit();
		case_t want;
		string name;
		int fails;
		want = cases[row];
		name = case_names[row];
		fails = field_differs(name, "pc", next_pc, commit.pc);
		fails += field_differs(name, "inst", want.inst, commit.inst);
		fails += field_differs(name, "illegal", want.illegal, commit.illegal);
		fails += field_differs(name, "rd_wena", !want.illegal, commit.rd_wena);
		// rd and data only mean something for a legal instruction
		if (!want.illegal) begin
			fails += field_differs(name, "rd_addr", want.inst[11:7], commit.rd_addr);
			fails += field_differs(name, "rd_data", want.value, commit.rd_data);
		end
		if (fails == 0) begin
			$display("pass    %s", name);
			passed++;
		end else begin
			failed++;
			errors++;
		end
		next_pc = next_pc + 64'd4;
		row++;
	endtask

	always @(posedge clock) begin
		if (was_reset && !reset && (inst_req !== 1'b0 || commit.valid !== 1'b0)) begin
			$display("inst_req or commit valid was not low when reset ended");
			errors++;
		end
		was_reset = reset;
		if (!reset && inst_req === 1'b1 && !addr_checked) begin
			addr_checked = 1'b1;
			if (inst_addr !== pc_start) begin
				$display("[ERROR] first_addr: expected %h, actual %h", pc_start, inst_addr);
				errors++;
			end
		end
		if (!reset && !finished && commit.valid === 1'b1) begin
			check_commit();
			if (row == NUM_CASES) begin
				$display("%0d tests passed, %0d failed, %0d errors in all", passed, failed, errors);
				finished = 1'b1;
			end
		end
	end

endmodule

//--- tests/core_tb.sv
// pc_start 0x8000_0000; fetch answers after 0 to 3 cycles, rows marked no_delay are answered at once
`timescale 1ns/1ps

module core_tb;

	localparam core_pkg::word_t pc_start = 64'h8000_0000;
	localparam int clock_period = 40;

	`include "tb_cases.svh"

	logic clock;
	logic reset;
	logic inst_req;
	core_pkg::word_t inst_addr;
	logic inst_ack;
	core_pkg::inst_t inst_data;
	core_pkg::commit_t commit;
	logic done;
	int error_count;
	integer seed;

	core_top #(
		.pc_start(pc_start)
	) i_core_top (
		.clock(clock),
		.reset(reset),
		.inst_req(inst_req),
		.inst_addr(inst_addr),
		.inst_ack(inst_ack),
		.inst_data(inst_data),
		.commit(commit)
	);

	commit_checker #(
		.pc_start(pc_start)
	) i_checker (
		.clock(clock),
		.reset(reset),
		.inst_req(inst_req),
		.inst_addr(inst_addr),
		.commit(commit),
		.done(done),
		.error_count(error_count)
	);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

	// four-phase responder
	initial begin
		int row;
		int delay;
		inst_ack = 1'b0;
		inst_data = core_pkg::NOP_INST;
		seed = 32'h6159;
		forever begin
			@(negedge clock);
			if (!reset && inst_req === 1'b1) begin
				row = int'((inst_addr - pc_start) >> 2);
				if (row >= 0 && row < NUM_CASES && cases[row].no_delay)
					delay = 0;
				else
					delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(negedge clock);
				if (row >= 0 && row < NUM_CASES)
					inst_data = cases[row].inst;
				else
					inst_data = core_pkg::NOP_INST;
				inst_ack = 1'b1;
				// hold ack until the request drops
				@(negedge clock);
				while (inst_req)
					@(negedge clock);
				inst_ack = 1'b0;
			end
		end
	end

	initial begin
		wait (done === 1'b1);
		@(negedge clock);
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(NUM_CASES * 10 * clock_period + 400);
		$display("commit stream stalled, only part of the table was committed");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+tests
source/core_pkg.sv
source/fetch_unit.sv
source/regfile.sv
source/decode_stage.sv
source/execute_stage.sv
source/core_top.sv
tests/commit_checker.sv
tests/core_tb.sv
